//--- flist.f
+incdir+rtl
rtl/accel_pkg.sv
rtl/axis_reg_slice.sv
rtl/job_ctrl.sv
rtl/conv_mac.sv
rtl/lrelu_requant.sv
rtl/maxpool_pair.sv
rtl/out_packer.sv
rtl/accel_top.sv
verification/accel_checker.sv
verification/accel_tb.sv

//--- rtl/accel_defines.svh
`ifndef ACCEL_DEFINES_SVH
`define ACCEL_DEFINES_SVH

// pixel, weight and output byte width
`define DATA_W 8

// taps per weight beat, pixels per pixel beat
`define TAPS 4

// four signed 8x8 products summed, incl. the -128*-128 corner
`define ACC_W 18

`define REQUANT_SHIFT 3'd4 // applied to every accumulator value
`define LRELU_SHIFT 3'd3   // extra shift for negative values only

// bytes per output word
`define OUT_LANES 4

`endif

//--- rtl/accel_pkg.sv
`include "accel_defines.svh"

package accel_pkg;

  typedef logic signed [`DATA_W-1:0] act_t;
  typedef logic signed [`ACC_W-1:0] acc_t;

  // lane 0 sits in the low bits
  typedef act_t [`TAPS-1:0] taps_t;

  // conv -> lrelu
  typedef struct packed {
    logic last;
    acc_t data;
  } acc_beat_t;

  // lrelu -> pool, pool -> packer
  typedef struct packed {
    logic last;
    act_t data;
  } act_beat_t;

  typedef struct packed {
    logic last;
    logic [`OUT_LANES-1:0] keep;
    logic [`OUT_LANES-1:0][`DATA_W-1:0] data;
  } out_word_t;

endpackage

//--- rtl/accel_top.sv
`include "accel_defines.svh"

module accel_top (
  input  logic                            aclk,
  input  logic                            rst,
  input  logic                            s_axis_weights_tvalid,
  output logic                            s_axis_weights_tready,
  input  accel_pkg::taps_t                s_axis_weights_tdata,
  input  logic                            s_axis_pixels_tvalid,
  output logic                            s_axis_pixels_tready,
  input  accel_pkg::taps_t                s_axis_pixels_tdata,
  input  logic                            s_axis_pixels_tlast,
  output logic                            m_axis_tvalid,
  input  logic                            m_axis_tready,
  output logic [`OUT_LANES*`DATA_W-1:0]   m_axis_tdata,
  output logic [`OUT_LANES-1:0]           m_axis_tkeep,
  output logic                            m_axis_tlast
);
  import accel_pkg::*;

  logic      weight_we;
  logic      pixels_accept; // conv_mac can take a pixel beat
  logic      conv_in_valid;
  logic      job_done;

  logic      conv_valid, conv_ready;
  acc_beat_t conv_beat;
  logic      acc_valid, acc_ready;
  acc_beat_t acc_beat;
  logic      lrelu_valid, lrelu_ready;
  act_beat_t lrelu_beat;
  logic      act_valid, act_ready;
  act_beat_t act_beat;
  logic      pool_valid, pool_ready;
  act_beat_t pool_beat;
  out_word_t packer_word;

  assign conv_in_valid = s_axis_pixels_tvalid && s_axis_pixels_tready;
  assign job_done      = m_axis_tvalid && m_axis_tready && m_axis_tlast;
  assign m_axis_tdata  = packer_word.data;
  assign m_axis_tkeep  = packer_word.keep;
  assign m_axis_tlast  = packer_word.last;

  job_ctrl job_ctrl_i (
    .aclk           (aclk                 ),
    .rst            (rst                  ),
    .weights_tvalid (s_axis_weights_tvalid),
    .weights_tready (s_axis_weights_tready),
    .pixels_tvalid  (s_axis_pixels_tvalid ),
    .pixels_tready  (s_axis_pixels_tready ),
    .pixels_tlast   (s_axis_pixels_tlast  ),
    .pixels_accept  (pixels_accept        ),
    .weight_we      (weight_we            ),
    .job_done       (job_done             )
  );

  conv_mac conv_mac_i (
    .aclk      (aclk                ),
    .rst       (rst                 ),
    .weight_we (weight_we           ),
    .weights   (s_axis_weights_tdata),
    .in_valid  (conv_in_valid       ),
    .in_ready  (pixels_accept       ),
    .pixels    (s_axis_pixels_tdata ),
    .in_last   (s_axis_pixels_tlast ),
    .out_valid (conv_valid          ),
    .out_ready (conv_ready          ),
    .out_beat  (conv_beat           )
  );

  axis_reg_slice #(.payload_t(acc_beat_t)) acc_slice_i (
    .aclk      (aclk      ),
    .rst       (rst       ),
    .in_valid  (conv_valid),
    .in_ready  (conv_ready),
    .in_data   (conv_beat ),
    .out_valid (acc_valid ),
    .out_ready (acc_ready ),
    .out_data  (acc_beat  )
  );

  lrelu_requant lrelu_requant_i (
    .aclk      (aclk       ),
    .rst       (rst        ),
    .in_valid  (acc_valid  ),
    .in_ready  (acc_ready  ),
    .in_beat   (acc_beat   ),
    .out_valid (lrelu_valid),
    .out_ready (lrelu_ready),
    .out_beat  (lrelu_beat )
  );

  axis_reg_slice #(.payload_t(act_beat_t)) act_slice_i (
    .aclk      (aclk       ),
    .rst       (rst        ),
    .in_valid  (lrelu_valid),
    .in_ready  (lrelu_ready),
    .in_data   (lrelu_beat ),
    .out_valid (act_valid  ),
    .out_ready (act_ready  ),
    .out_data  (act_beat   )
  );

  maxpool_pair maxpool_pair_i (
    .aclk      (aclk      ),
    .rst       (rst       ),
    .in_valid  (act_valid ),
    .in_ready  (act_ready ),
    .in_beat   (act_beat  ),
    .out_valid (pool_valid),
    .out_ready (pool_ready),
    .out_beat  (pool_beat )
  );

  out_packer out_packer_i (
    .aclk      (aclk         ),
    .rst       (rst          ),
    .in_valid  (pool_valid   ),
    .in_ready  (pool_ready   ),
    .in_beat   (pool_beat    ),
    .out_valid (m_axis_tvalid),
    .out_ready (m_axis_tready),
    .out_word  (packer_word  )
  );

endmodule

//--- rtl/axis_reg_slice.sv
module axis_reg_slice #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     aclk,
  input  logic     rst,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  // free when empty or draining this cycle
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge aclk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (in_valid && in_ready) begin
      out_data <= in_data;
    end
  end

endmodule

//--- rtl/conv_mac.sv
`include "accel_defines.svh"

module conv_mac (
  input  logic                  aclk,
  input  logic                  rst,
  input  logic                  weight_we,
  input  accel_pkg::taps_t      weights,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  accel_pkg::taps_t      pixels,
  input  logic                  in_last,
  output logic                  out_valid,
  input  logic                  out_ready,
  output accel_pkg::acc_beat_t  out_beat
);
  import accel_pkg::*;

  taps_t weight_q;
  acc_t  dot;

  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge aclk) begin
    if (weight_we) weight_q <= weights; // one load per job
  end

  always_comb begin
    dot = '0;
    for (int i = 0; i < `TAPS; i++) begin
      dot = dot + acc_t'($signed(pixels[i])) * acc_t'($signed(weight_q[i]));
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (in_valid && in_ready) begin
      out_beat.data <= dot;
      out_beat.last <= in_last;
    end
  end

endmodule

//--- rtl/job_ctrl.sv
module job_ctrl (
  input  logic aclk,
  input  logic rst,
  input  logic weights_tvalid,
  output logic weights_tready,
  input  logic pixels_tvalid,
  output logic pixels_tready,
  input  logic pixels_tlast,
  input  logic pixels_accept,
  output logic weight_we,
  input  logic job_done
);

  typedef enum logic [1:0] {
    LOAD  = 2'd0, // waiting for the weight beat
    RUN   = 2'd1, // image streaming
    DRAIN = 2'd2  // image in, results still leaving
  } state_t;

  state_t state;
  state_t state_next;
  logic   last_pixel;

  assign weights_tready = (state == LOAD);
  assign pixels_tready  = (state == RUN) && pixels_accept;
  assign weight_we      = weights_tvalid && weights_tready;
  assign last_pixel     = pixels_tvalid && pixels_tready && pixels_tlast;

  always_comb begin
    state_next = state;
    case (state)
      LOAD: begin
        if (weight_we) state_next = RUN;
      end
      RUN: begin
        if (last_pixel) state_next = DRAIN;
      end
      DRAIN: begin
        // weights stay locked until the tlast word has left the packer
        if (job_done) state_next = LOAD;
      end
      default: state_next = LOAD;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      state <= LOAD;
    end else begin
      state <= state_next;
    end
  end

endmodule

//--- rtl/lrelu_requant.sv
`include "accel_defines.svh"

module lrelu_requant (
  input  logic                  aclk,
  input  logic                  rst,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  accel_pkg::acc_beat_t  in_beat,
  output logic                  out_valid,
  input  logic                  out_ready,
  output accel_pkg::act_beat_t  out_beat
);
  import accel_pkg::*;

  localparam acc_t ACT_MAX = acc_t'(2 ** (`DATA_W - 1) - 1);
  localparam acc_t ACT_MIN = acc_t'(-(2 ** (`DATA_W - 1)));

  acc_t scaled;
  act_t sat;

  assign in_ready = !out_valid || out_ready;

  always_comb begin
    scaled = in_beat.data >>> `REQUANT_SHIFT;
    if (scaled[`ACC_W-1]) scaled = scaled >>> `LRELU_SHIFT; // leaky slope 1/8
    if (scaled > ACT_MAX) begin
      sat = act_t'(ACT_MAX);
    end else if (scaled < ACT_MIN) begin
      sat = act_t'(ACT_MIN);
    end else begin
      sat = act_t'(scaled);
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (in_valid && in_ready) begin
      out_beat.data <= sat;
      out_beat.last <= in_beat.last;
    end
  end

endmodule

//--- rtl/maxpool_pair.sv
module maxpool_pair (
  input  logic                  aclk,
  input  logic                  rst,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  accel_pkg::act_beat_t  in_beat,
  output logic                  out_valid,
  input  logic                  out_ready,
  output accel_pkg::act_beat_t  out_beat
);
  import accel_pkg::*;

  logic have_first; // first of the pair is held
  act_t first_val;
  logic take;
  logic emit;
  act_t pair_max;

  assign in_ready = !out_valid || out_ready;
  assign take     = in_valid && in_ready;
  assign emit     = have_first || in_beat.last; // lone last goes out by itself
  assign pair_max = (have_first && first_val > in_beat.data) ? first_val : in_beat.data;

  always_ff @(posedge aclk) begin
    if (rst) begin
      out_valid  <= 1'b0;
      have_first <= 1'b0;
    end else begin
      if (out_ready) out_valid <= 1'b0;
      if (take) begin
        if (emit) begin
          out_valid  <= 1'b1;
          have_first <= 1'b0;
        end else begin
          have_first <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (take) begin
      if (emit) begin
        out_beat.data <= pair_max;
        out_beat.last <= in_beat.last;
      end else begin
        first_val <= in_beat.data;
      end
    end
  end

endmodule

//--- rtl/out_packer.sv
`include "accel_defines.svh"

module out_packer (
  input  logic                  aclk,
  input  logic                  rst,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  accel_pkg::act_beat_t  in_beat,
  output logic                  out_valid,
  input  logic                  out_ready,
  output accel_pkg::out_word_t  out_word
);

  localparam int LANE_W = $clog2(`OUT_LANES);
  localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(`OUT_LANES - 1);

  logic [LANE_W-1:0]                  lane; // next lane to fill
  logic [`OUT_LANES-1:0]              fill_keep;
  logic [`OUT_LANES-1:0][`DATA_W-1:0] fill_data;
  logic [`OUT_LANES-1:0]              next_keep;
  logic [`OUT_LANES-1:0][`DATA_W-1:0] next_data;
  logic                               take;
  logic                               flush;

  assign in_ready  = !out_valid || out_ready;
  assign take      = in_valid && in_ready;
  assign flush     = in_beat.last || (lane == LAST_LANE);
  assign next_keep = fill_keep | (`OUT_LANES'(1) << lane);

  always_comb begin
    for (int i = 0; i < `OUT_LANES; i++) begin
      if (i == int'(lane)) begin
        next_data[i] = in_beat.data;
      end else if (fill_keep[i]) begin
        next_data[i] = fill_data[i];
      end else begin
        next_data[i] = '0; // unused high lanes of a short word
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      out_valid <= 1'b0;
      lane      <= '0;
      fill_keep <= '0;
    end else begin
      if (out_ready) out_valid <= 1'b0;
      if (take && flush) begin
        out_valid <= 1'b1;
        lane      <= '0;
        fill_keep <= '0;
      end else if (take) begin
        lane      <= lane + 1'b1;
        fill_keep <= next_keep;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (take) begin
      fill_data <= next_data;
      if (flush) begin
        out_word.data <= next_data;
        out_word.keep <= next_keep;
        out_word.last <= in_beat.last;
      end
    end
  end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module accel_tb -o accel_sim
./obj_dir/accel_sim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TEST OK" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi

//--- verification/accel_checker.sv
`include "accel_defines.svh"

module accel_checker (
  input logic                          aclk,
  input logic                          rst,
  input logic                          weights_tvalid,
  input logic                          weights_tready,
  input logic                          pixels_tready,
  input logic                          m_axis_tvalid,
  input logic                          m_axis_tready,
  input logic [`OUT_LANES*`DATA_W-1:0] m_axis_tdata,
  input logic [`OUT_LANES-1:0]         m_axis_tkeep,
  input logic                          m_axis_tlast
);
  timeunit 1ns;
  timeprecision 100ps;
  import accel_pkg::*;

  localparam int WORD_W = `OUT_LANES * `DATA_W;

  out_word_t             exp_q[$];
  out_word_t             expected;
  logic [WORD_W-1:0]     mask;
  int                    data_errors = 0;
  int                    protocol_errors = 0;
  int                    words_checked = 0;
  logic                  seen_weight; // first weight beat taken
  logic                  job_open;    // weights in, tlast word not yet out
  logic                  hold_q;      // output stalled last edge
  logic [WORD_W-1:0]     held_data;
  logic [`OUT_LANES-1:0] held_keep;
  logic                  held_last;

  task automatic expect_word(input out_word_t word);
    exp_q.push_back(word);
  endtask

  function automatic int pending();
    return exp_q.size();
  endfunction

  function automatic logic [WORD_W-1:0] lane_mask(input logic [`OUT_LANES-1:0] keep);
    logic [WORD_W-1:0] m;
    for (int i = 0; i < `OUT_LANES; i++) begin
      m[i*`DATA_W +: `DATA_W] = {`DATA_W{keep[i]}};
    end
    return m;
  endfunction

  always @(posedge aclk) begin
    if (rst) begin
      seen_weight <= 1'b0;
      job_open    <= 1'b0;
      hold_q      <= 1'b0;
    end else begin
      if (weights_tvalid && weights_tready) begin
        seen_weight <= 1'b1;
        job_open    <= 1'b1;
      end else if (m_axis_tvalid && m_axis_tready && m_axis_tlast) begin
        job_open <= 1'b0;
      end
      hold_q    <= m_axis_tvalid && !m_axis_tready;
      held_data <= m_axis_tdata;
      held_keep <= m_axis_tkeep;
      held_last <= m_axis_tlast;
    end
  end

  idle_after_reset: assert property (@(posedge aclk) disable iff (rst)
    !seen_weight |-> (!m_axis_tvalid && !pixels_tready && weights_tready))
    else begin
      protocol_errors++;
      $write("[ERROR] m_axis_tvalid/s_axis_pixels_tready/s_axis_weights_tready");
      $display(" expected 0/0/1 got %h/%h/%h before the first weight beat",
               m_axis_tvalid, pixels_tready, weights_tready);
    end

  weights_locked: assert property (@(posedge aclk) disable iff (rst) job_open |-> !weights_tready)
    else begin
      protocol_errors++;
      $display("[ERROR] s_axis_weights_tready expected 0 got %h during a job", weights_tready);
    end

  valid_held: assert property (@(posedge aclk) disable iff (rst) hold_q |-> m_axis_tvalid)
    else begin
      protocol_errors++;
      $display("[ERROR] m_axis_tvalid expected 1 got %h while stalled", m_axis_tvalid);
    end

  data_held: assert property (@(posedge aclk) disable iff (rst)
    hold_q |-> (m_axis_tdata == held_data))
    else begin
      protocol_errors++;
      $display("[ERROR] m_axis_tdata expected %h got %h while stalled", held_data, m_axis_tdata);
    end

  side_held: assert property (@(posedge aclk) disable iff (rst)
    hold_q |-> (m_axis_tkeep == held_keep && m_axis_tlast == held_last))
    else begin
      protocol_errors++;
      $display("[ERROR] m_axis_tkeep/tlast expected %h/%h got %h/%h while stalled",
               held_keep, held_last, m_axis_tkeep, m_axis_tlast);
    end

  // every accepted word against the model queue
  always @(posedge aclk) begin
    if (!rst && m_axis_tvalid && m_axis_tready) begin
      if (exp_q.size() == 0) begin
        protocol_errors++;
        $display("an output word arrived when no word was expected");
      end else begin
        expected = exp_q.pop_front();
        mask     = lane_mask(expected.keep);
        words_checked++;
        assert ((m_axis_tdata & mask) == (expected.data & mask))
          else begin
            data_errors++;
            $display("[ERROR] m_axis_tdata expected %h got %h", expected.data & mask,
                     m_axis_tdata & mask);
          end
        assert (m_axis_tkeep == expected.keep)
          else begin
            data_errors++;
            $display("[ERROR] m_axis_tkeep expected %h got %h", expected.keep, m_axis_tkeep);
          end
        assert (m_axis_tlast == expected.last)
          else begin
            data_errors++;
            $display("[ERROR] m_axis_tlast expected %h got %h", expected.last, m_axis_tlast);
          end
      end
    end
  end

endmodule

//--- verification/accel_tb.sv
`include "accel_defines.svh"

module accel_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import accel_pkg::*;

  localparam int TIMEOUT_CYCLES = 2000;
  localparam int WAIT_WEIGHT    = 0;
  localparam int WAIT_PIXEL     = 1;
  localparam int WAIT_DONE      = 2;

  logic                          aclk;
  logic                          rst;
  logic                          s_axis_weights_tvalid;
  logic                          s_axis_weights_tready;
  taps_t                         s_axis_weights_tdata;
  logic                          s_axis_pixels_tvalid;
  logic                          s_axis_pixels_tready;
  taps_t                         s_axis_pixels_tdata;
  logic                          s_axis_pixels_tlast;
  logic                          m_axis_tvalid;
  logic                          m_axis_tready;
  logic [`OUT_LANES*`DATA_W-1:0] m_axis_tdata;
  logic [`OUT_LANES-1:0]         m_axis_tkeep;
  logic                          m_axis_tlast;
  logic                          backpressure;
  logic                          timed_out;
  taps_t                         pix_q[$]; // pixel beats of the current job

  always #20 aclk = ~aclk;

  // output ready, random while back-pressure is on
  always @(posedge aclk) begin
    #2;
    m_axis_tready = backpressure ? ($urandom % 4 != 0) : 1'b1;
  end

  accel_top accel_top_i (
    .aclk                  (aclk                 ),
    .rst                   (rst                  ),
    .s_axis_weights_tvalid (s_axis_weights_tvalid),
    .s_axis_weights_tready (s_axis_weights_tready),
    .s_axis_weights_tdata  (s_axis_weights_tdata ),
    .s_axis_pixels_tvalid  (s_axis_pixels_tvalid ),
    .s_axis_pixels_tready  (s_axis_pixels_tready ),
    .s_axis_pixels_tdata   (s_axis_pixels_tdata  ),
    .s_axis_pixels_tlast   (s_axis_pixels_tlast  ),
    .m_axis_tvalid         (m_axis_tvalid        ),
    .m_axis_tready         (m_axis_tready        ),
    .m_axis_tdata          (m_axis_tdata         ),
    .m_axis_tkeep          (m_axis_tkeep         ),
    .m_axis_tlast          (m_axis_tlast         )
  );

  accel_checker accel_checker_i (
    .aclk           (aclk                 ),
    .rst            (rst                  ),
    .weights_tvalid (s_axis_weights_tvalid),
    .weights_tready (s_axis_weights_tready),
    .pixels_tready  (s_axis_pixels_tready ),
    .m_axis_tvalid  (m_axis_tvalid        ),
    .m_axis_tready  (m_axis_tready        ),
    .m_axis_tdata   (m_axis_tdata         ),
    .m_axis_tkeep   (m_axis_tkeep         ),
    .m_axis_tlast   (m_axis_tlast         )
  );

  function automatic int dot_of(input taps_t w, input taps_t p);
    int sum;
    sum = 0;
    for (int i = 0; i < `TAPS; i++) begin
      sum += int'(p[i]) * int'(w[i]);
    end
    return sum;
  endfunction

  // requantize, leaky slope on negatives, clamp to a signed byte
  function automatic int act_of(input int acc);
    int s;
    s = acc >>> `REQUANT_SHIFT;
    if (s < 0) s = s >>> `LRELU_SHIFT;
    if (s > 127) s = 127;
    if (s < -128) s = -128;
    return s;
  endfunction

  task automatic model_job(input taps_t w);
    int        acts[$];
    int        pooled[$];
    out_word_t word;
    int        lane;
    foreach (pix_q[i]) acts.push_back(act_of(dot_of(w, pix_q[i])));
    for (int i = 0; i < acts.size(); i += 2) begin
      if (i + 1 < acts.size()) pooled.push_back(acts[i] > acts[i+1] ? acts[i] : acts[i+1]);
      else pooled.push_back(acts[i]); // lone last value
    end
    word = '0;
    lane = 0;
    foreach (pooled[i]) begin
      word.data[lane] = 8'(pooled[i]);
      word.keep[lane] = 1'b1;
      word.last       = (i == pooled.size() - 1);
      lane++;
      if (lane == `OUT_LANES || word.last) begin
        accel_checker_i.expect_word(word);
        word = '0;
        lane = 0;
      end
    end
  endtask

  // handshake seen at the negedge completes on the next rising edge
  task automatic wait_xfer(input int which, input string what);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < TIMEOUT_CYCLES) begin
      @(negedge aclk);
      case (which)
        WAIT_WEIGHT: seen = s_axis_weights_tready;
        WAIT_PIXEL:  seen = s_axis_pixels_tready;
        default:     seen = m_axis_tvalid && m_axis_tready && m_axis_tlast;
      endcase
      @(posedge aclk);
      #2;
      cycles++;
    end
    if (!seen) begin
      $display("timeout: no %s within %0d cycles", what, TIMEOUT_CYCLES);
      timed_out = 1'b1;
    end
  endtask

  task automatic run_job(input taps_t w, input int beats, input bit saturate, input bit bp);
    pix_q.delete();
    for (int b = 0; b < beats; b++) begin
      if (saturate) pix_q.push_back(taps_t'((b % 4 < 2) ? {`TAPS{8'h7f}} : {`TAPS{8'h80}}));
      else pix_q.push_back(taps_t'($urandom));
    end
    model_job(w);
    backpressure          = bp;
    s_axis_weights_tdata  = w;
    s_axis_weights_tvalid = 1'b1;
    wait_xfer(WAIT_WEIGHT, "weight beat handshake");
    s_axis_weights_tvalid = 1'b0;
    foreach (pix_q[b]) begin
      if (timed_out) return;
      s_axis_pixels_tdata  = pix_q[b];
      s_axis_pixels_tlast  = (b == pix_q.size() - 1);
      s_axis_pixels_tvalid = 1'b1;
      wait_xfer(WAIT_PIXEL, "pixel beat handshake");
      s_axis_pixels_tvalid = 1'b0;
      if ($urandom % 4 == 0) begin
        @(posedge aclk); // idle gap on the pixel stream
        #2;
      end
    end
    s_axis_pixels_tlast = 1'b0;
    if (!timed_out) wait_xfer(WAIT_DONE, "output word with tlast");
  endtask

  initial begin
    aclk                  = 1'b0;
    rst                   = 1'b1;
    s_axis_weights_tvalid = 1'b0;
    s_axis_weights_tdata  = '0;
    s_axis_pixels_tvalid  = 1'b0;
    s_axis_pixels_tdata   = '0;
    s_axis_pixels_tlast   = 1'b0;
    m_axis_tready         = 1'b0;
    backpressure          = 1'b0;
    timed_out             = 1'b0;
    void'($urandom(32'hc404));
    repeat (3) @(posedge aclk);
    #2;
    rst = 1'b0;
    repeat (4) @(posedge aclk); // idle with no weights offered
    #2;
    run_job(taps_t'($urandom), 16, 1'b0, 1'b0);
    if (!timed_out) run_job(taps_t'($urandom), 13, 1'b0, 1'b1);
    if (!timed_out) run_job(taps_t'($urandom), 10, 1'b0, 1'b1);
    if (!timed_out) run_job(taps_t'({`TAPS{8'h7f}}), 8, 1'b1, 1'b1);
    $display("words checked %0d, data errors %0d, protocol errors %0d, words missing %0d",
             accel_checker_i.words_checked, accel_checker_i.data_errors,
             accel_checker_i.protocol_errors, accel_checker_i.pending());
    if (timed_out || accel_checker_i.data_errors != 0 || accel_checker_i.protocol_errors != 0 ||
        accel_checker_i.pending() != 0) begin
      $display("TEST FAILED");
    end else begin
      $display("TEST OK");
    end
    $finish;
  end

endmodule
